// File: src.f
logic/bpPkg.sv
logic/bankRouter.sv
logic/counterBank.sv
logic/targetBuffer.sv
logic/predictionSelect.sv
logic/branchPredictUnit.sv
verif/branchPredictUnitTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = branchPredictUnitTb
FILELIST  = src.f
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# pass only when the run prints the pass message
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJDIR)

// File: verif/branchPredictUnitTb.sv
// testbench for the branch prediction unit
// directed operation table, then xorshift-driven updates and queries against a model
`timescale 1ns/1ns

module branchPredictUnitTb;

    localparam int RAND_OPS = 300;

    logic                   clk;
    logic                   resetn;
    logic [31:0]            fetchPc;
    logic                   exValid;
    logic [31:0]            exPc;
    bpPkg::brKind_e         exKind;
    logic                   exTaken;
    logic [31:0]            exTarget;
    logic                   predictTaken;
    logic [31:0]            predictedPc;

    // operation table, one entry per cycle
    logic                   opIsUpdate [$];
    logic [31:0]            opPc       [$];
    bpPkg::brKind_e         opKind     [$];
    logic                   opTaken    [$];
    logic [31:0]            opAddr     [$];
    logic                   tableReady;

    // reference model state
    bpPkg::ctrState_e       refCtr    [256];
    logic                   refValid  [32];
    logic [24:0]            refTag    [32];
    bpPkg::brKind_e         refKind   [32];
    logic [31:0]            refTarget [32];
    logic [31:0]            refRas    [16];
    logic [3:0]             refPtr;

    int                     errors;
    int                     checks;
    logic [31:0]            seed;

    branchPredictUnit UUT (
        .clk(clk), .resetn(resetn), .fetchPc(fetchPc), .exValid(exValid),
        .exPc(exPc), .exKind(exKind), .exTaken(exTaken), .exTarget(exTarget),
        .predictTaken(predictTaken), .predictedPc(predictedPc)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic addUpdate(input logic [31:0] pc, input bpPkg::brKind_e kind,
                             input logic taken, input logic [31:0] target);
        opIsUpdate.push_back(1'b1);
        opPc.push_back(pc);
        opKind.push_back(kind);
        opTaken.push_back(taken);
        opAddr.push_back(target);
    endtask

    task automatic addQuery(input logic [31:0] pc, input logic expTaken,
                            input logic [31:0] expPc);
        opIsUpdate.push_back(1'b0);
        opPc.push_back(pc);
        opKind.push_back(bpPkg::KIND_NONE);
        opTaken.push_back(expTaken);
        opAddr.push_back(expPc);
    endtask

    task automatic modelReset();
        for (int i = 0; i < 256; i++) begin
            refCtr[i] = bpPkg::CTR_SNT;
        end
        for (int i = 0; i < 32; i++) begin
            refValid[i] = 1'b0;
        end
        for (int i = 0; i < 16; i++) begin
            refRas[i] = 32'd0;
        end
        refPtr = 4'd0;
    endtask

    task automatic modelTrain(input logic [31:0] pc, input bpPkg::brKind_e kind,
                              input logic taken, input logic [31:0] target);
        logic [7:0] row;
        logic [4:0] idx;
        row = pc[9:2];
        idx = pc[6:2];
        if (kind == bpPkg::KIND_JUMP) begin
            if (taken && refCtr[row] != bpPkg::CTR_ST) begin
                refCtr[row] = bpPkg::ctrState_e'(refCtr[row] + 2'd1);
            end else if (!taken && refCtr[row] != bpPkg::CTR_SNT) begin
                refCtr[row] = bpPkg::ctrState_e'(refCtr[row] - 2'd1);
            end
        end
        if (taken && kind != bpPkg::KIND_NONE) begin
            refValid[idx]  = 1'b1;
            refTag[idx]    = pc[31:7];
            refKind[idx]   = kind;
            refTarget[idx] = target;
            if (kind == bpPkg::KIND_CALL) begin
                refRas[refPtr] = pc + 32'd8;
                refPtr = refPtr + 4'd1;
            end else if (kind == bpPkg::KIND_RET) begin
                refPtr = refPtr - 4'd1;
            end
        end
    endtask

    function automatic void modelPredict(input logic [31:0] pc, output logic expTaken,
                                         output logic [31:0] expPc);
        logic [4:0] idx;
        logic [3:0] topPtr;
        logic       hit;
        logic       dirTaken;
        idx      = pc[6:2];
        topPtr   = refPtr - 4'd1;
        hit      = refValid[idx] && (refTag[idx] == pc[31:7]);
        dirTaken = (refCtr[pc[9:2]] == bpPkg::CTR_WT) || (refCtr[pc[9:2]] == bpPkg::CTR_ST);
        expTaken = 1'b0;
        expPc    = pc + 32'd8;
        if (hit && (refKind[idx] == bpPkg::KIND_RET)) begin
            expTaken = 1'b1;
            expPc    = refRas[topPtr];
        end else if (hit && (refKind[idx] == bpPkg::KIND_CALL ||
                             (refKind[idx] == bpPkg::KIND_JUMP && dirTaken))) begin
            expTaken = 1'b1;
            expPc    = refTarget[idx];
        end
    endfunction

    task automatic applyUpdate(input logic [31:0] pc, input bpPkg::brKind_e kind,
                               input logic taken, input logic [31:0] target);
        exValid  = 1'b1;
        exPc     = pc;
        exKind   = kind;
        exTaken  = taken;
        exTarget = target;
        modelTrain(pc, kind, taken, target);
    endtask

    // prediction is combinational, sampled mid-cycle
    task automatic runQuery(input logic [31:0] pc, input logic expTaken,
                            input logic [31:0] expPc);
        exValid = 1'b0;
        fetchPc = pc;
        #4;
        checks++;
        if (predictTaken !== expTaken || predictedPc !== expPc) begin
            errors++;
            $display("[ERROR] %0t ns: pc %h expected taken %0b next %h, got taken %0b next %h",
                     $time, pc, expTaken, expPc, predictTaken, predictedPc);
        end
    endtask

    task automatic buildTable();
        logic [31:0] callPc;
        // out of reset nothing is predicted
        addQuery(32'h0000_0000, 1'b0, 32'h0000_0008);
        addQuery(32'h0040_0100, 1'b0, 32'h0040_0108);
        addQuery(32'hFFFF_FFFC, 1'b0, 32'h0000_0004);
        // jump in bank 0 row 2, counter walks up to strong and back
        addUpdate(32'h0040_0020, bpPkg::KIND_JUMP, 1'b1, 32'h0040_0400);
        addQuery(32'h0040_0020, 1'b0, 32'h0040_0028);
        addUpdate(32'h0040_0020, bpPkg::KIND_JUMP, 1'b1, 32'h0040_0400);
        addQuery(32'h0040_0020, 1'b1, 32'h0040_0400);
        addUpdate(32'h0040_0020, bpPkg::KIND_JUMP, 1'b1, 32'h0040_0400);
        addUpdate(32'h0040_0020, bpPkg::KIND_JUMP, 1'b1, 32'h0040_0400);
        addUpdate(32'h0040_0020, bpPkg::KIND_JUMP, 1'b0, 32'h0040_0400);
        addQuery(32'h0040_0020, 1'b1, 32'h0040_0400);
        // same index, other tag, while the shared row counter predicts taken
        addQuery(32'h0080_0020, 1'b0, 32'h0080_0028);
        addUpdate(32'h0040_0020, bpPkg::KIND_JUMP, 1'b0, 32'h0040_0400);
        addQuery(32'h0040_0020, 1'b0, 32'h0040_0028);
        // banks 1 and 2 at row 2
        addUpdate(32'h0040_0024, bpPkg::KIND_JUMP, 1'b1, 32'h0040_0500);
        addUpdate(32'h0040_0024, bpPkg::KIND_JUMP, 1'b1, 32'h0040_0500);
        addUpdate(32'h0040_0028, bpPkg::KIND_JUMP, 1'b1, 32'h0040_0600);
        addQuery(32'h0040_0020, 1'b0, 32'h0040_0028);
        addQuery(32'h0040_0024, 1'b1, 32'h0040_0500);
        addQuery(32'h0040_0028, 1'b0, 32'h0040_0030);
        // ret installed first, pointer wraps to 15, then two nested calls
        addUpdate(32'h0040_3040, bpPkg::KIND_RET, 1'b1, 32'h0000_0000);
        addUpdate(32'h0040_1000, bpPkg::KIND_CALL, 1'b1, 32'h0040_2000);
        addUpdate(32'h0040_2010, bpPkg::KIND_CALL, 1'b1, 32'h0040_3000);
        addQuery(32'h0040_3040, 1'b1, 32'h0040_2018);
        addUpdate(32'h0040_3040, bpPkg::KIND_RET, 1'b1, 32'h0000_0000);
        addQuery(32'h0040_3040, 1'b1, 32'h0040_1008);
        addQuery(32'h0040_1000, 1'b1, 32'h0040_2000);
        // seventeen calls from pointer 0, the first one is overwritten
        for (int k = 0; k < 17; k++) begin
            callPc = 32'h0050_0000 + k * 32'h100;
            addUpdate(callPc, bpPkg::KIND_CALL, 1'b1, 32'h0060_0000);
        end
        for (int k = 16; k > 0; k--) begin
            callPc = 32'h0050_0000 + k * 32'h100;
            addQuery(32'h0040_3040, 1'b1, callPc + 32'd8);
            addUpdate(32'h0040_3040, bpPkg::KIND_RET, 1'b1, 32'h0000_0000);
        end
        addQuery(32'h0040_3040, 1'b1, 32'h0050_1008);
    endtask

    initial begin
        wait (tableReady);
        #((opPc.size() + RAND_OPS + 20) * 10);
        $display("timeout: the testbench did not reach the end of its operations in time");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic [31:0]    r;
        logic [31:0]    t;
        logic [31:0]    pc;
        logic           expTaken;
        logic [31:0]    expPc;
        clk        = 1'b0;
        resetn     = 1'b0;
        fetchPc    = 32'd0;
        exValid    = 1'b0;
        exPc       = 32'd0;
        exKind     = bpPkg::KIND_NONE;
        exTaken    = 1'b0;
        exTarget   = 32'd0;
        errors     = 0;
        checks     = 0;
        seed       = 32'ha5a1;
        tableReady = 1'b0;
        buildTable();
        modelReset();
        tableReady = 1'b1;

        repeat (8) @(posedge clk);
        #1;
        resetn = 1'b1;

        for (int i = 0; i < opPc.size(); i++) begin
            @(posedge clk);
            #1;
            if (opIsUpdate[i]) begin
                applyUpdate(opPc[i], opKind[i], opTaken[i], opAddr[i]);
            end else begin
                runQuery(opPc[i], opTaken[i], opAddr[i]);
            end
        end

        // small PC window so entries get reused, taken three times in four
        for (int n = 0; n < RAND_OPS; n++) begin
            seed = xorshift32(seed);
            r    = seed;
            seed = xorshift32(seed);
            t    = seed;
            pc   = {20'h00400, r[11:2], 2'b00};
            @(posedge clk);
            #1;
            if (r[15]) begin
                applyUpdate(pc, bpPkg::brKind_e'(r[13:12]), r[14] | r[16], {t[31:2], 2'b00});
            end else begin
                modelPredict(pc, expTaken, expPc);
                runQuery(pc, expTaken, expPc);
            end
        end

        @(posedge clk);
        #1;
        exValid = 1'b0;
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: logic/branchPredictUnit.sv
// branch prediction unit top level
// router, banked direction counters, target buffer and selector
`timescale 1ns/1ns

module branchPredictUnit (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [bpPkg::PC_W-1:0] fetchPc,
    input  logic                   exValid,
    input  logic [bpPkg::PC_W-1:0] exPc,
    input  bpPkg::brKind_e         exKind,
    input  logic                   exTaken,
    input  logic [bpPkg::PC_W-1:0] exTarget,
    output logic                   predictTaken,
    output logic [bpPkg::PC_W-1:0] predictedPc
);

    logic [bpPkg::BANK_SEL_W-1:0] fetchBank;
    logic [bpPkg::ROW_W-1:0]      bankRow;
    logic [bpPkg::NUM_BANKS-1:0]  bankWe;
    logic [bpPkg::ROW_W-1:0]      updRow;
    logic                         updTaken;
    logic [bpPkg::NUM_BANKS-1:0]  bankDir;
    logic                         btbHit;
    bpPkg::brKind_e               btbKind;
    logic [bpPkg::PC_W-1:0]       btbTarget;
    logic [bpPkg::PC_W-1:0]       rasTop;

    bankRouter router (
        .fetchPc(fetchPc), .exValid(exValid), .exPc(exPc), .exKind(exKind),
        .exTaken(exTaken), .fetchBank(fetchBank), .bankRow(bankRow),
        .bankWe(bankWe), .updRow(updRow), .updTaken(updTaken)
    );

    // every bank sees the fetch row, only one gets the update
    for (genvar i = 0; i < bpPkg::NUM_BANKS; i++) begin : genBank
        counterBank bank (
            .clk(clk), .resetn(resetn), .bankRow(bankRow), .we(bankWe[i]),
            .updRow(updRow), .updTaken(updTaken), .dir(bankDir[i])
        );
    end

    targetBuffer btb (
        .clk(clk), .resetn(resetn), .fetchPc(fetchPc), .exValid(exValid),
        .exPc(exPc), .exKind(exKind), .exTaken(exTaken), .exTarget(exTarget),
        .btbHit(btbHit), .btbKind(btbKind), .btbTarget(btbTarget), .rasTop(rasTop)
    );

    predictionSelect select (
        .fetchPc(fetchPc), .fetchBank(fetchBank), .bankDir(bankDir),
        .btbHit(btbHit), .btbKind(btbKind), .btbTarget(btbTarget), .rasTop(rasTop),
        .predictTaken(predictTaken), .predictedPc(predictedPc)
    );

endmodule

// File: logic/predictionSelect.sv
// picks the fetch bank direction and forms the next fetch address
// from the target buffer hit, the branch kind and the return stack
`timescale 1ns/1ns

module predictionSelect (
    input  logic [bpPkg::PC_W-1:0]       fetchPc,
    input  logic [bpPkg::BANK_SEL_W-1:0] fetchBank,
    input  logic [bpPkg::NUM_BANKS-1:0]  bankDir,
    input  logic                         btbHit,
    input  bpPkg::brKind_e               btbKind,
    input  logic [bpPkg::PC_W-1:0]       btbTarget,
    input  logic [bpPkg::PC_W-1:0]       rasTop,
    output logic                         predictTaken,
    output logic [bpPkg::PC_W-1:0]       predictedPc
);

    logic                   fetchDir;
    logic [bpPkg::PC_W-1:0] fallThroughPc;

    assign fetchDir      = bankDir[fetchBank];
    assign fallThroughPc = fetchPc + bpPkg::FALL_THROUGH;

    always_comb begin
        predictTaken = 1'b0;
        predictedPc  = fallThroughPc;
        if (btbHit) begin
            case (btbKind)
                bpPkg::KIND_RET: begin
                    predictTaken = 1'b1;
                    predictedPc  = rasTop;
                end
                bpPkg::KIND_CALL: begin
                    predictTaken = 1'b1;
                    predictedPc  = btbTarget;
                end
                // jumps follow their direction counter
                bpPkg::KIND_JUMP: begin
                    if (fetchDir) begin
                        predictTaken = 1'b1;
                        predictedPc  = btbTarget;
                    end
                end
                default: begin
                    predictTaken = 1'b0;
                end
            endcase
        end
    end

endmodule

// File: logic/targetBuffer.sv
// direct-mapped branch target buffer with tag compare
// wrapping return address stack fed by resolved calls and returns
`timescale 1ns/1ns

module targetBuffer (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic [bpPkg::PC_W-1:0]  fetchPc,
    input  logic                    exValid,
    input  logic [bpPkg::PC_W-1:0]  exPc,
    input  bpPkg::brKind_e          exKind,
    input  logic                    exTaken,
    input  logic [bpPkg::PC_W-1:0]  exTarget,
    output logic                    btbHit,
    output bpPkg::brKind_e          btbKind,
    output logic [bpPkg::PC_W-1:0]  btbTarget,
    output logic [bpPkg::PC_W-1:0]  rasTop
);

    logic [bpPkg::BTB_ENTRIES-1:0] validBuf;
    logic [bpPkg::BTB_TAG_W-1:0]   tagBuf    [bpPkg::BTB_ENTRIES];
    logic [bpPkg::PC_W-1:0]        targetBuf [bpPkg::BTB_ENTRIES];
    bpPkg::brKind_e                kindBuf   [bpPkg::BTB_ENTRIES];

    logic [bpPkg::PC_W-1:0]      ras [bpPkg::RAS_DEPTH];
    logic [bpPkg::RAS_PTR_W-1:0] rasPtr;
    logic [bpPkg::RAS_PTR_W-1:0] rasTopPtr;

    logic [bpPkg::BTB_IDX_W-1:0] fetchIdx;
    logic [bpPkg::BTB_TAG_W-1:0] fetchTag;
    logic [bpPkg::BTB_IDX_W-1:0] exIdx;
    logic [bpPkg::BTB_TAG_W-1:0] exTag;

    logic btbWe;
    logic rasPush;
    logic rasPop;

    assign fetchIdx = fetchPc[bpPkg::BTB_IDX_LSB +: bpPkg::BTB_IDX_W];
    assign fetchTag = fetchPc[bpPkg::BTB_TAG_LSB +: bpPkg::BTB_TAG_W];
    assign exIdx    = exPc[bpPkg::BTB_IDX_LSB +: bpPkg::BTB_IDX_W];
    assign exTag    = exPc[bpPkg::BTB_TAG_LSB +: bpPkg::BTB_TAG_W];

    // lookup, combinational from the fetch PC
    assign btbHit    = validBuf[fetchIdx] && (tagBuf[fetchIdx] == fetchTag);
    assign btbKind   = kindBuf[fetchIdx];
    assign btbTarget = targetBuf[fetchIdx];

    // top of stack sits just below the pointer
    assign rasTopPtr = rasPtr - bpPkg::RAS_PTR_W'(1);
    assign rasTop    = ras[rasTopPtr];

    // taken control transfers of a known kind allocate an entry
    assign btbWe   = exValid && exTaken && (exKind != bpPkg::KIND_NONE);
    assign rasPush = btbWe && (exKind == bpPkg::KIND_CALL);
    assign rasPop  = btbWe && (exKind == bpPkg::KIND_RET);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            validBuf <= '0;
        end else if (btbWe) begin
            validBuf[exIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (btbWe) begin
            tagBuf[exIdx]    <= exTag;
            targetBuf[exIdx] <= exTarget;
            kindBuf[exIdx]   <= exKind;
        end
    end

    // entries and pointer clear on reset
    // a push on a full stack overwrites the oldest entry
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rasPtr <= '0;
            for (int i = 0; i < bpPkg::RAS_DEPTH; i++) begin
                ras[i] <= '0;
            end
        end else if (rasPush) begin
            ras[rasPtr] <= exPc + bpPkg::FALL_THROUGH;
            rasPtr      <= rasPtr + bpPkg::RAS_PTR_W'(1);
        end else if (rasPop) begin
            rasPtr <= rasTopPtr;
        end
    end

    // stack pointer comes out of reset empty
    assert property (@(posedge clk) !resetn |=> (rasPtr == '0))
        else $error("targetBuffer: stack pointer %0d after reset", rasPtr);

endmodule

// File: logic/counterBank.sv
// one bank of two-bit saturating direction counters
// fetch read port and execute update port
`timescale 1ns/1ns

module counterBank (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic [bpPkg::ROW_W-1:0] bankRow,
    input  logic                    we,
    input  logic [bpPkg::ROW_W-1:0] updRow,
    input  logic                    updTaken,
    output logic                    dir
);

    bpPkg::ctrState_e [bpPkg::BANK_ROWS-1:0] ctr;
    bpPkg::ctrState_e                        ctrNext;

    // one saturating step toward the resolved direction
    always_comb begin
        case (ctr[updRow])
            bpPkg::CTR_SNT: ctrNext = updTaken ? bpPkg::CTR_WNT : bpPkg::CTR_SNT;
            bpPkg::CTR_WNT: ctrNext = updTaken ? bpPkg::CTR_WT : bpPkg::CTR_SNT;
            bpPkg::CTR_WT:  ctrNext = updTaken ? bpPkg::CTR_ST : bpPkg::CTR_WNT;
            default:        ctrNext = updTaken ? bpPkg::CTR_ST : bpPkg::CTR_WT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < bpPkg::BANK_ROWS; i++) begin
                ctr[i] <= bpPkg::CTR_SNT;
            end
        end else if (we) begin
            ctr[updRow] <= ctrNext;
        end
    end

    // MSB of the counter is the predicted direction
    // same-cycle update is not bypassed, fetch sees the old state
    assign dir = ctr[bankRow][1];

    // no counter in this bank moves unless the bank is written
    assert property (@(posedge clk) disable iff (!resetn) !we |=> $stable(ctr))
        else $error("counterBank: counter changed without a write enable");

endmodule

// File: logic/bankRouter.sv
// bank select and row decode for the fetch and execute PCs
// steers a direction update to a single counter bank
`timescale 1ns/1ns

module bankRouter (
    input  logic [bpPkg::PC_W-1:0]       fetchPc,
    input  logic                         exValid,
    input  logic [bpPkg::PC_W-1:0]       exPc,
    input  bpPkg::brKind_e               exKind,
    input  logic                         exTaken,
    output logic [bpPkg::BANK_SEL_W-1:0] fetchBank,
    output logic [bpPkg::ROW_W-1:0]      bankRow,
    output logic [bpPkg::NUM_BANKS-1:0]  bankWe,
    output logic [bpPkg::ROW_W-1:0]      updRow,
    output logic                         updTaken
);

    logic [bpPkg::BANK_SEL_W-1:0] exBank;
    logic                         trainDir;

    assign fetchBank = fetchPc[bpPkg::BANK_LSB +: bpPkg::BANK_SEL_W];
    assign bankRow   = fetchPc[bpPkg::ROW_LSB +: bpPkg::ROW_W];
    assign exBank    = exPc[bpPkg::BANK_LSB +: bpPkg::BANK_SEL_W];
    assign updRow    = exPc[bpPkg::ROW_LSB +: bpPkg::ROW_W];
    assign updTaken  = exTaken;

    // only resolved direct jumps train the direction counters
    assign trainDir = exValid && (exKind == bpPkg::KIND_JUMP);

    always_comb begin
        for (int i = 0; i < bpPkg::NUM_BANKS; i++) begin
            bankWe[i] = trainDir && (exBank == i[bpPkg::BANK_SEL_W-1:0]);
        end
    end

    // at most one bank may be written per update
    always_comb begin
        assert ($onehot0(bankWe))
            else $error("bankRouter: more than one bank write enable 0x%h", bankWe);
    end

endmodule

// File: logic/bpPkg.sv
// sizes, address field positions and enums shared by the branch predictor
package bpPkg;

    localparam int PC_W = 32;

    // direction table is split into banks by PC bits 3:2
    localparam int NUM_BANKS = 4;
    localparam int BANK_SEL_W = 2;
    localparam int BANK_LSB = 2;
    localparam int BANK_ROWS = 64;
    localparam int ROW_W = 6;
    localparam int ROW_LSB = BANK_LSB + BANK_SEL_W;

    // direct-mapped target buffer, index from bits 6:2, tag from 31:7
    localparam int BTB_ENTRIES = 32;
    localparam int BTB_IDX_W = 5;
    localparam int BTB_IDX_LSB = 2;
    localparam int BTB_TAG_W = 25;
    localparam int BTB_TAG_LSB = BTB_IDX_LSB + BTB_IDX_W;

    // return address stack
    localparam int RAS_DEPTH = 16;
    localparam int RAS_PTR_W = 4;

    // delay slot puts the sequential successor at PC+8
    localparam logic [PC_W-1:0] FALL_THROUGH = 32'd8;

    typedef enum logic [1:0] {
        KIND_NONE = 2'b00,  // not a predicted branch, or JALR
        KIND_RET  = 2'b01,
        KIND_JUMP = 2'b10,  // direct branch or jump
        KIND_CALL = 2'b11
    } brKind_e;

    typedef enum logic [1:0] {
        CTR_SNT = 2'b00,
        CTR_WNT = 2'b01,
        CTR_WT  = 2'b10,
        CTR_ST  = 2'b11
    } ctrState_e;

endpackage
